// File: source/rv32v_pkg.sv
package rv32v_pkg;

    // register file geometry
    localparam int NUM_LANES = 4;
    localparam int VLEN      = 128;

    // one element or one bank word
    typedef logic [31:0] word_t;

    // vector register number
    typedef logic [4:0] vreg_sel_t;

    // micro-op index within a vector instruction
    typedef logic [4:0] uop_num_t;

    // element width codes, the fourth code is reserved
    typedef logic [1:0] sew_t;

    localparam sew_t SEW8  = 2'd0;
    localparam sew_t SEW16 = 2'd1;
    localparam sew_t SEW32 = 2'd2;

    // lane alu opcodes
    typedef logic [4:0] valu_op_t;

    localparam valu_op_t VALU_ADD   = 5'd0;
    localparam valu_op_t VALU_SUB   = 5'd1;
    localparam valu_op_t VALU_RSUB  = 5'd2;
    localparam valu_op_t VALU_AND   = 5'd3;
    localparam valu_op_t VALU_OR    = 5'd4;
    localparam valu_op_t VALU_XOR   = 5'd5;

    localparam valu_op_t VALU_SLL   = 5'd6;
    localparam valu_op_t VALU_SRL   = 5'd7;
    localparam valu_op_t VALU_SRA   = 5'd8;

    localparam valu_op_t VALU_MINU  = 5'd9;
    localparam valu_op_t VALU_MAXU  = 5'd10;

    // compares produce 1 or 0 per element
    localparam valu_op_t VALU_SEQ   = 5'd11;
    localparam valu_op_t VALU_SNE   = 5'd12;
    localparam valu_op_t VALU_SLT   = 5'd13;
    localparam valu_op_t VALU_SLE   = 5'd14;
    localparam valu_op_t VALU_SGT   = 5'd15;

    // last defined opcode
    localparam valu_op_t VALU_MERGE = 5'd16;

endpackage

// File: source/rv32v_vector_bank.sv
`timescale 1ns/1ps

module rv32v_vector_bank (
    input  logic                 CLK,
    input  logic                 reset,
    input  rv32v_pkg::vreg_sel_t vs1,
    input  rv32v_pkg::vreg_sel_t vs2,
    input  rv32v_pkg::vreg_sel_t vw,
    input  rv32v_pkg::word_t     vwdata,
    input  logic [3:0]           byte_wen,
    output rv32v_pkg::word_t     vdat1,
    output rv32v_pkg::word_t     vdat2,
    output rv32v_pkg::word_t     v0
);

    // one 32-bit slice of every vector register
    rv32v_pkg::word_t regs [32];

    always_ff @(posedge CLK) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else begin
            // only the enabled bytes of the addressed word change
            for (int b = 0; b < 4; b++) begin
                if (byte_wen[b]) begin
                    regs[vw][8*b +: 8] <= vwdata[8*b +: 8];
                end
            end
        end
    end

    // reads see the contents before this cycle's write
    assign vdat1 = regs[vs1];
    assign vdat2 = regs[vs2];

    // mask register slice, always visible
    assign v0 = regs[0];

    // writeback enables come from outside the execute stage
    byte_wen_known: assert property (
        @(posedge CLK) disable iff (reset) !$isunknown(byte_wen)
    ) else $error("vector bank: byte_wen is unknown");

endmodule

// File: source/rv32v_read_xbar.sv
`timescale 1ns/1ps

module rv32v_read_xbar (
    input  rv32v_pkg::word_t [rv32v_pkg::NUM_LANES-1:0] bank_dat,
    input  rv32v_pkg::sew_t                             veew,
    input  logic [1:0]                                  bank_offset,
    input  logic                                        sign_ext,
    output rv32v_pkg::word_t [rv32v_pkg::NUM_LANES-1:0] out_dat
);

    for (genvar k = 0; k < rv32v_pkg::NUM_LANES; k++) begin : g_lane
        logic [7:0]       elem8;
        logic [15:0]      elem16;
        rv32v_pkg::word_t elem_ext;

        // sew8: the micro-op fills one bank, lane k takes byte k
        assign elem8 = bank_dat[bank_offset][8*k +: 8];

        // sew16: two banks per micro-op, two halfwords per bank
        assign elem16 = bank_dat[{bank_offset[0], 1'(k / 2)}][16*(k % 2) +: 16];

        always_comb begin
            case (veew)
                rv32v_pkg::SEW8: begin
                    elem_ext = sign_ext ? {{24{elem8[7]}}, elem8} : {24'b0, elem8};
                end
                rv32v_pkg::SEW16: begin
                    elem_ext = sign_ext ? {{16{elem16[15]}}, elem16} : {16'b0, elem16};
                end
                default: begin
                    // sew32 lane k is bank k
                    elem_ext = bank_dat[k];
                end
            endcase
        end

        assign out_dat[k] = elem_ext;
    end

    always_comb begin
        assert ($isunknown(veew) || (veew inside {rv32v_pkg::SEW8, rv32v_pkg::SEW16,
                                                  rv32v_pkg::SEW32}))
            else $error("read xbar: reserved element width code %0d", veew);
    end

endmodule

// File: source/rv32v_vfu.sv
`timescale 1ns/1ps

module rv32v_vfu (
    input  rv32v_pkg::word_t    vopA,
    input  rv32v_pkg::word_t    vopB,
    input  logic                mask_bit,
    input  rv32v_pkg::sew_t     vsew,
    input  logic                sign_ext,
    input  rv32v_pkg::valu_op_t vop,
    output rv32v_pkg::word_t    vres
);

    function automatic rv32v_pkg::word_t extend_elem(input rv32v_pkg::word_t val,
                                                     input rv32v_pkg::sew_t  sew,
                                                     input logic             sx);
        case (sew)
            rv32v_pkg::SEW8:  return sx ? {{24{val[7]}}, val[7:0]} : {24'b0, val[7:0]};
            rv32v_pkg::SEW16: return sx ? {{16{val[15]}}, val[15:0]} : {16'b0, val[15:0]};
            default:          return val;
        endcase
    endfunction

    rv32v_pkg::word_t a_sx, a_zx, b_sx, b_zx;
    rv32v_pkg::word_t a_ext, b_ext;
    rv32v_pkg::word_t raw_res;
    logic [4:0]       shamt;

    assign a_sx  = extend_elem(vopA, vsew, 1'b1);
    assign a_zx  = extend_elem(vopA, vsew, 1'b0);
    assign b_sx  = extend_elem(vopB, vsew, 1'b1);
    assign b_zx  = extend_elem(vopB, vsew, 1'b0);
    assign a_ext = sign_ext ? a_sx : a_zx;
    assign b_ext = sign_ext ? b_sx : b_zx;

    // shift amount wraps at the element width
    always_comb begin
        case (vsew)
            rv32v_pkg::SEW8:  shamt = {2'b0, vopB[2:0]};
            rv32v_pkg::SEW16: shamt = {1'b0, vopB[3:0]};
            default:          shamt = vopB[4:0];
        endcase
    end

    // only the low sew bits of raw_res are kept
    always_comb begin
        case (vop)
            rv32v_pkg::VALU_ADD:   raw_res = vopA + vopB;
            rv32v_pkg::VALU_SUB:   raw_res = vopA - vopB;
            rv32v_pkg::VALU_RSUB:  raw_res = vopB - vopA;
            rv32v_pkg::VALU_AND:   raw_res = vopA & vopB;
            rv32v_pkg::VALU_OR:    raw_res = vopA | vopB;
            rv32v_pkg::VALU_XOR:   raw_res = vopA ^ vopB;
            rv32v_pkg::VALU_SLL:   raw_res = vopA << shamt;
            rv32v_pkg::VALU_SRL:   raw_res = a_zx >> shamt;
            rv32v_pkg::VALU_SRA:   raw_res = $signed(a_sx) >>> shamt;
            rv32v_pkg::VALU_MINU:  raw_res = (a_zx < b_zx) ? vopA : vopB;
            rv32v_pkg::VALU_MAXU:  raw_res = (a_zx > b_zx) ? vopA : vopB;
            rv32v_pkg::VALU_SEQ:   raw_res = {31'b0, a_ext == b_ext};
            rv32v_pkg::VALU_SNE:   raw_res = {31'b0, a_ext != b_ext};
            rv32v_pkg::VALU_SLT:   raw_res = {31'b0, $signed(a_ext) < $signed(b_ext)};
            rv32v_pkg::VALU_SLE:   raw_res = {31'b0, $signed(a_ext) <= $signed(b_ext)};
            rv32v_pkg::VALU_SGT:   raw_res = {31'b0, $signed(a_ext) > $signed(b_ext)};
            rv32v_pkg::VALU_MERGE: raw_res = mask_bit ? vopB : vopA;
            default:               raw_res = '0;
        endcase
    end

    assign vres = extend_elem(raw_res, vsew, sign_ext);

    always_comb begin
        assert ($isunknown(vop) || vop <= rv32v_pkg::VALU_MERGE)
            else $error("vfu: undefined alu opcode %0d", vop);
    end

endmodule

// File: source/rv32v_mask_unit.sv
`timescale 1ns/1ps

module rv32v_mask_unit (
    input  logic [rv32v_pkg::VLEN-1:0]      v0,
    input  logic                            mask_enable,
    input  rv32v_pkg::uop_num_t             uop_num,
    input  logic [rv32v_pkg::NUM_LANES-1:0] lane_active,
    output logic [rv32v_pkg::NUM_LANES-1:0] lane_mask,
    output logic [rv32v_pkg::NUM_LANES-1:0] mask_bits
);

    // one v0 bit per element, four elements per micro-op
    logic [6:0] bit_base;

    assign bit_base  = {uop_num, 2'b00};
    assign mask_bits = v0[bit_base +: rv32v_pkg::NUM_LANES];

    // unmasked ops only follow the lane active enables
    assign lane_mask = lane_active & (~{rv32v_pkg::NUM_LANES{mask_enable}} | mask_bits);

endmodule

// File: source/rv32v_ex_datapath.sv
`timescale 1ns/1ps

module rv32v_ex_datapath (
    input  logic                                        CLK,
    input  logic                                        reset,
    input  logic                                        ex_valid,
    input  rv32v_pkg::word_t                            rdat1,
    input  rv32v_pkg::word_t                            rdat2,
    input  rv32v_pkg::vreg_sel_t                        vs1_sel,
    input  rv32v_pkg::vreg_sel_t                        vs2_sel,
    input  rv32v_pkg::sew_t                             veew_src1,
    input  rv32v_pkg::sew_t                             veew_src2,
    input  rv32v_pkg::sew_t                             veew_dest,
    input  logic                                        vsignext,
    input  logic [4:0]                                  vimm,
    input  logic                                        vxin1_use_imm,
    input  logic                                        vxin1_use_rs1,
    input  logic                                        vxin2_use_rs2,
    input  rv32v_pkg::valu_op_t                         valuop,
    input  logic                                        vmask_en,
    input  rv32v_pkg::uop_num_t                         vuop_num,
    input  logic [rv32v_pkg::NUM_LANES-1:0]             vlaneactive,
    input  logic                                        vmemdren,
    input  logic                                        vmemdwen,
    input  logic                                        vregwen,
    input  rv32v_pkg::vreg_sel_t                        vd_sel,
    input  rv32v_pkg::vreg_sel_t                        wb_vd,
    input  rv32v_pkg::word_t [rv32v_pkg::NUM_LANES-1:0] wb_vwdata,
    input  logic [4*rv32v_pkg::NUM_LANES-1:0]           wb_byte_wen,
    output logic                                        mem_valid,
    output rv32v_pkg::word_t [rv32v_pkg::NUM_LANES-1:0] mem_valu_res,
    output rv32v_pkg::word_t [rv32v_pkg::NUM_LANES-1:0] mem_vs3,
    output logic [rv32v_pkg::NUM_LANES-1:0]             mem_lane_mask,
    output logic                                        mem_vregwen,
    output logic                                        mem_memdren,
    output logic                                        mem_memdwen,
    output rv32v_pkg::vreg_sel_t                        mem_vd_sel,
    output rv32v_pkg::sew_t                             mem_veew,
    output rv32v_pkg::uop_num_t                         mem_uop_num
);

    logic [rv32v_pkg::VLEN-1:0]                  v0;
    rv32v_pkg::word_t [rv32v_pkg::NUM_LANES-1:0] bank_src1, bank_src2;
    rv32v_pkg::word_t [rv32v_pkg::NUM_LANES-1:0] xbar_src1, xbar_src2;
    rv32v_pkg::word_t [rv32v_pkg::NUM_LANES-1:0] vopA, vopB;
    rv32v_pkg::word_t [rv32v_pkg::NUM_LANES-1:0] valu_res;
    logic [rv32v_pkg::NUM_LANES-1:0]             mask_bits;
    logic [rv32v_pkg::NUM_LANES-1:0]             lane_mask;
    rv32v_pkg::word_t                            ext_imm;
    rv32v_pkg::word_t                            rs1_narrow;
    logic                                        cmp_op;

    // bank k holds bits 32k+31:32k of every register
    for (genvar b = 0; b < rv32v_pkg::NUM_LANES; b++) begin : g_bank
        rv32v_vector_bank bank_i (
            .CLK      (CLK),
            .reset    (reset),
            .vs1      (vs1_sel),
            .vs2      (vs2_sel),
            .vw       (wb_vd),
            .vwdata   (wb_vwdata[b]),
            .byte_wen (wb_byte_wen[4*b +: 4]),
            .vdat1    (bank_src1[b]),
            .vdat2    (bank_src2[b]),
            .v0       (v0[32*b +: 32])
        );
    end

    rv32v_read_xbar src1_xbar_i (
        .bank_dat    (bank_src1),
        .veew        (veew_src1),
        .bank_offset (vuop_num[1:0]),
        .sign_ext    (vsignext),
        .out_dat     (xbar_src1)
    );

    rv32v_read_xbar src2_xbar_i (
        .bank_dat    (bank_src2),
        .veew        (veew_src2),
        .bank_offset (vuop_num[1:0]),
        .sign_ext    (vsignext),
        .out_dat     (xbar_src2)
    );

    // compares always take a signed immediate
    assign cmp_op = valuop inside {rv32v_pkg::VALU_SEQ, rv32v_pkg::VALU_SNE,
                                   rv32v_pkg::VALU_SLT, rv32v_pkg::VALU_SLE,
                                   rv32v_pkg::VALU_SGT};

    assign ext_imm = (vsignext || cmp_op) ? {{27{vimm[4]}}, vimm} : {27'b0, vimm};

    // memory micro-ops use rs1 as a full address
    always_comb begin
        rs1_narrow = rdat1;
        if (!(vmemdren || vmemdwen)) begin
            case (veew_src1)
                rv32v_pkg::SEW8: begin
                    rs1_narrow = vsignext ? {{24{rdat1[7]}}, rdat1[7:0]} : {24'b0, rdat1[7:0]};
                end
                rv32v_pkg::SEW16: begin
                    rs1_narrow = vsignext ? {{16{rdat1[15]}}, rdat1[15:0]}
                                          : {16'b0, rdat1[15:0]};
                end
                default: begin
                    rs1_narrow = rdat1;
                end
            endcase
        end
    end

    always_comb begin
        if (vxin1_use_imm) begin
            vopB = {rv32v_pkg::NUM_LANES{ext_imm}};
        end else if (vxin1_use_rs1) begin
            vopB = {rv32v_pkg::NUM_LANES{rs1_narrow}};
        end else begin
            vopB = xbar_src1;
        end
    end

    assign vopA = vxin2_use_rs2 ? {rv32v_pkg::NUM_LANES{rdat2}} : xbar_src2;

    for (genvar k = 0; k < rv32v_pkg::NUM_LANES; k++) begin : g_lane
        rv32v_vfu vfu_i (
            .vopA     (vopA[k]),
            .vopB     (vopB[k]),
            .mask_bit (mask_bits[k]),
            .vsew     (veew_src2),
            .sign_ext (vsignext),
            .vop      (valuop),
            .vres     (valu_res[k])
        );
    end

    rv32v_mask_unit mask_unit_i (
        .v0          (v0),
        .mask_enable (vmask_en),
        .uop_num     (vuop_num),
        .lane_active (vlaneactive),
        .lane_mask   (lane_mask),
        .mask_bits   (mask_bits)
    );

    // execute/memory latch, enables only set for a valid micro-op
    always_ff @(posedge CLK) begin
        if (reset) begin
            mem_valid   <= 1'b0;
            mem_vregwen <= 1'b0;
            mem_memdren <= 1'b0;
            mem_memdwen <= 1'b0;
        end else begin
            mem_valid   <= ex_valid;
            mem_vregwen <= ex_valid & vregwen;
            mem_memdren <= ex_valid & vmemdren;
            mem_memdwen <= ex_valid & vmemdwen;
        end
    end

    always_ff @(posedge CLK) begin
        mem_valu_res  <= valu_res;
        mem_vs3       <= xbar_src1;
        mem_lane_mask <= ex_valid ? lane_mask : '0;
        mem_vd_sel    <= vd_sel;
        mem_veew      <= veew_dest;
        mem_uop_num   <= vuop_num;
    end

endmodule

// File: testbench/rv32v_ex_datapath_tb.sv
`timescale 1ns/1ps

module rv32v_ex_datapath_tb;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 10;
    localparam int N_WRITES     = 12;
    localparam int N_PER_WIDTH  = 4;
    localparam int N_OPSEL      = 40;
    localparam int N_MASK       = 40;
    localparam int N_STREAM     = 24;
    // a single micro-op or write takes an issue cycle and a drain cycle
    localparam int TOTAL_CYCLES = RESET_CYCLES + N_STREAM + 4
        + 2 * (32 + N_WRITES + 32 + 17 * 3 * N_PER_WIDTH + N_OPSEL + 1 + N_MASK);

    logic CLK, reset, ex_valid, vsignext, vxin1_use_imm, vxin1_use_rs1, vxin2_use_rs2;
    logic vmask_en, vmemdren, vmemdwen, vregwen;
    logic mem_valid, mem_vregwen, mem_memdren, mem_memdwen;
    rv32v_pkg::word_t     rdat1, rdat2;
    rv32v_pkg::vreg_sel_t vs1_sel, vs2_sel, vd_sel, wb_vd, mem_vd_sel;
    rv32v_pkg::sew_t      veew_src1, veew_src2, veew_dest, mem_veew;
    rv32v_pkg::valu_op_t  valuop;
    rv32v_pkg::uop_num_t  vuop_num, mem_uop_num;
    logic [4:0]           vimm;
    logic [3:0]           vlaneactive, mem_lane_mask;
    logic [15:0]          wb_byte_wen;
    logic [127:0]         wb_vwdata, mem_valu_res, mem_vs3;

    // fields of the next micro-op
    rv32v_pkg::valu_op_t  n_op;
    rv32v_pkg::vreg_sel_t n_vs1, n_vs2, n_vd;
    rv32v_pkg::sew_t      n_sew1, n_sew2, n_sewd;
    rv32v_pkg::uop_num_t  n_uop;
    rv32v_pkg::word_t     n_rdat1, n_rdat2;
    logic [4:0]           n_imm;
    logic [3:0]           n_active;
    logic n_sx, n_use_imm, n_use_rs1, n_use_rs2, n_mask_en, n_memr, n_memw, n_regwen;

    logic [127:0] shadow [32];
    logic [127:0] exp_res_q [$];
    logic [127:0] exp_vs3_q [$];
    logic [3:0]   exp_mask_q [$];
    logic [15:0]  exp_ctrl_q [$];
    logic [31:0]  lfsr;
    int           errors;

    rv32v_ex_datapath dut_i (
        .CLK(CLK), .reset(reset), .ex_valid(ex_valid), .rdat1(rdat1), .rdat2(rdat2),
        .vs1_sel(vs1_sel), .vs2_sel(vs2_sel), .veew_src1(veew_src1), .veew_src2(veew_src2),
        .veew_dest(veew_dest), .vsignext(vsignext), .vimm(vimm),
        .vxin1_use_imm(vxin1_use_imm), .vxin1_use_rs1(vxin1_use_rs1),
        .vxin2_use_rs2(vxin2_use_rs2), .valuop(valuop), .vmask_en(vmask_en),
        .vuop_num(vuop_num), .vlaneactive(vlaneactive), .vmemdren(vmemdren),
        .vmemdwen(vmemdwen), .vregwen(vregwen), .vd_sel(vd_sel), .wb_vd(wb_vd),
        .wb_vwdata(wb_vwdata), .wb_byte_wen(wb_byte_wen), .mem_valid(mem_valid),
        .mem_valu_res(mem_valu_res), .mem_vs3(mem_vs3), .mem_lane_mask(mem_lane_mask),
        .mem_vregwen(mem_vregwen), .mem_memdren(mem_memdren), .mem_memdwen(mem_memdwen),
        .mem_vd_sel(mem_vd_sel), .mem_veew(mem_veew), .mem_uop_num(mem_uop_num)
    );

    initial begin
        CLK = 1'b0;
        forever #(CLK_PERIOD / 2) CLK = ~CLK;
    end

    initial begin
        #((TOTAL_CYCLES + 100) * CLK_PERIOD);
        $display("watchdog: the tests did not finish in the expected time");
        $display("Test FAILED");
        $fatal(1, "watchdog timeout");
    end

    // galois lfsr stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            val  = {val[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return val;
    endfunction

    function automatic logic [31:0] extend_to_word(input logic [31:0] val,
                                                   input logic [1:0] sew, input logic sx);
        logic [31:0] keep;
        logic [31:0] msb;
        keep = (sew == 2'd0) ? 32'h0000_00ff : (sew == 2'd1) ? 32'h0000_ffff : 32'hffff_ffff;
        msb  = keep ^ (keep >> 1);
        if (sx && (val & msb) != '0) begin
            return val | ~keep;
        end
        return val & keep;
    endfunction

    // element 4*uop+lane sits at byte offset element*width inside the register
    function automatic logic [31:0] xbar_elem(input logic [127:0] vreg, input logic [1:0] sew,
                                              input logic [4:0] uop, input int lane,
                                              input logic sx);
        int           byte_off;
        logic [127:0] shifted;
        byte_off = ((4 * int'(uop) + lane) * (1 << sew)) % 16;
        shifted  = vreg >> (8 * byte_off);
        return extend_to_word(shifted[31:0], sew, sx);
    endfunction

    function automatic logic [31:0] alu_model(input logic [4:0] op, input logic [31:0] a,
                                              input logic [31:0] b, input logic mbit,
                                              input logic [1:0] sew, input logic sx);
        int                 sh;
        logic [31:0]        al, bl, as, bs, raw;
        logic signed [31:0] sa;
        sh  = int'(b[4:0]) % (8 << sew);
        al  = extend_to_word(a, sew, 1'b0);
        bl  = extend_to_word(b, sew, 1'b0);
        as  = extend_to_word(a, sew, sx);
        bs  = extend_to_word(b, sew, sx);
        sa  = extend_to_word(a, sew, 1'b1);
        raw = '0;
        case (op)
            rv32v_pkg::VALU_ADD:   raw = a + b;
            rv32v_pkg::VALU_SUB:   raw = a - b;
            rv32v_pkg::VALU_RSUB:  raw = b - a;
            rv32v_pkg::VALU_AND:   raw = a & b;
            rv32v_pkg::VALU_OR:    raw = a | b;
            rv32v_pkg::VALU_XOR:   raw = a ^ b;
            rv32v_pkg::VALU_SLL:   raw = a << sh;
            rv32v_pkg::VALU_SRL:   raw = al >> sh;
            rv32v_pkg::VALU_SRA:   raw = sa >>> sh;
            rv32v_pkg::VALU_MINU:  raw = (al < bl) ? al : bl;
            rv32v_pkg::VALU_MAXU:  raw = (al > bl) ? al : bl;
            rv32v_pkg::VALU_SEQ:   raw = {31'b0, as == bs};
            rv32v_pkg::VALU_SNE:   raw = {31'b0, as != bs};
            rv32v_pkg::VALU_SLT:   raw = {31'b0, $signed(as) < $signed(bs)};
            rv32v_pkg::VALU_SLE:   raw = {31'b0, $signed(as) <= $signed(bs)};
            rv32v_pkg::VALU_SGT:   raw = {31'b0, $signed(as) > $signed(bs)};
            rv32v_pkg::VALU_MERGE: raw = mbit ? b : a;
            default:               raw = '0;
        endcase
        return extend_to_word(raw, sew, sx);
    endfunction

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
            $display("Test FAILED");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic random_uop();
        n_op      = 5'(rand_bits(5) % 17);
        n_vs1     = 5'(rand_bits(5));
        n_vs2     = 5'(rand_bits(5));
        n_vd      = 5'(rand_bits(5));
        n_sew1    = 2'(rand_bits(8) % 3);
        n_sew2    = n_sew1;
        n_sewd    = 2'(rand_bits(8) % 3);
        n_uop     = 5'(rand_bits(5));
        n_rdat1   = rand_bits(32);
        n_rdat2   = rand_bits(32);
        n_imm     = 5'(rand_bits(5));
        n_sx      = rand_bits(1) != 0;
        n_memr    = rand_bits(1) != 0;
        n_memw    = rand_bits(1) != 0;
        n_regwen  = rand_bits(1) != 0;
        n_use_imm = 1'b0;
        n_use_rs1 = 1'b0;
        n_use_rs2 = 1'b0;
        n_mask_en = 1'b0;
        n_active  = 4'hf;
    endtask

    task automatic write_reg(input logic [4:0] vd, input logic [127:0] data,
                             input logic [15:0] be);
        @(posedge CLK);
        wb_vd       <= vd;
        wb_vwdata   <= data;
        wb_byte_wen <= be;
        for (int i = 0; i < 16; i++) begin
            if (be[i]) begin
                shadow[vd][8*i +: 8] = data[8*i +: 8];
            end
        end
        @(posedge CLK);
        wb_byte_wen <= '0;
    endtask

    // drives the next micro-op and queues what the latch must show for it
    task automatic drive_uop();
        logic [127:0] res, vs3;
        logic [31:0]  opa, opb, immw, rs1w;
        logic [3:0]   mbits;
        logic         cmp;
        @(posedge CLK);
        ex_valid      <= 1'b1;
        valuop        <= n_op;
        vs1_sel       <= n_vs1;
        vs2_sel       <= n_vs2;
        vd_sel        <= n_vd;
        veew_src1     <= n_sew1;
        veew_src2     <= n_sew2;
        veew_dest     <= n_sewd;
        vuop_num      <= n_uop;
        rdat1         <= n_rdat1;
        rdat2         <= n_rdat2;
        vimm          <= n_imm;
        vsignext      <= n_sx;
        vxin1_use_imm <= n_use_imm;
        vxin1_use_rs1 <= n_use_rs1;
        vxin2_use_rs2 <= n_use_rs2;
        vmask_en      <= n_mask_en;
        vlaneactive   <= n_active;
        vmemdren      <= n_memr;
        vmemdwen      <= n_memw;
        vregwen       <= n_regwen;
        mbits = shadow[0][4 * int'(n_uop) +: 4];
        cmp   = n_op inside {rv32v_pkg::VALU_SEQ, rv32v_pkg::VALU_SNE, rv32v_pkg::VALU_SLT,
                             rv32v_pkg::VALU_SLE, rv32v_pkg::VALU_SGT};
        immw  = (n_sx || cmp) ? 32'($signed(n_imm)) : 32'(n_imm);
        rs1w  = (n_memr || n_memw) ? n_rdat1 : extend_to_word(n_rdat1, n_sew1, n_sx);
        for (int k = 0; k < 4; k++) begin
            vs3[32*k +: 32] = xbar_elem(shadow[n_vs1], n_sew1, n_uop, k, n_sx);
            opb = n_use_imm ? immw : (n_use_rs1 ? rs1w : vs3[32*k +: 32]);
            opa = n_use_rs2 ? n_rdat2 : xbar_elem(shadow[n_vs2], n_sew2, n_uop, k, n_sx);
            res[32*k +: 32] = alu_model(n_op, opa, opb, mbits[k], n_sew2, n_sx);
        end
        exp_res_q.push_back(res);
        exp_vs3_q.push_back(vs3);
        exp_mask_q.push_back(n_active & (~{4{n_mask_en}} | mbits));
        exp_ctrl_q.push_back({1'b1, n_regwen, n_memr, n_memw, n_vd, n_sewd, n_uop});
    endtask

    task automatic check_oldest();
        check_value("mem_valu_res", mem_valu_res, exp_res_q.pop_front());
        check_value("mem_vs3", mem_vs3, exp_vs3_q.pop_front());
        check_value("mem_lane_mask", 128'(mem_lane_mask), 128'(exp_mask_q.pop_front()));
        check_value("mem_{valid,vregwen,memdren,memdwen,vd_sel,veew,uop_num}",
                    128'({mem_valid, mem_vregwen, mem_memdren, mem_memdwen, mem_vd_sel,
                          mem_veew, mem_uop_num}), 128'(exp_ctrl_q.pop_front()));
    endtask

    task automatic exec_uop();
        drive_uop();
        @(posedge CLK);
        ex_valid <= 1'b0;
        @(negedge CLK);
        check_oldest();
    endtask

    task automatic reset_state_test();
        @(negedge CLK);
        check_value("mem_{valid,vregwen,memdren,memdwen}",
                    128'({mem_valid, mem_vregwen, mem_memdren, mem_memdwen}), '0);
        for (int r = 0; r < 32; r++) begin
            random_uop();
            n_op   = rv32v_pkg::VALU_ADD;
            n_vs1  = 5'(r);
            n_vs2  = 5'(r);
            n_sew1 = rv32v_pkg::SEW32;
            n_sew2 = rv32v_pkg::SEW32;
            exec_uop();
            check_value("mem_valu_res", mem_valu_res, '0);
            check_value("mem_vs3", mem_vs3, '0);
        end
    endtask

    task automatic write_readback_test();
        logic [127:0] data;
        for (int i = 0; i < N_WRITES; i++) begin
            for (int j = 0; j < 4; j++) begin
                data[32*j +: 32] = rand_bits(32);
            end
            write_reg(5'(rand_bits(5)), data, 16'(rand_bits(16)));
        end
        // OR of a register with itself reads it back whole
        for (int r = 0; r < 32; r++) begin
            random_uop();
            n_op   = rv32v_pkg::VALU_OR;
            n_vs1  = 5'(r);
            n_vs2  = 5'(r);
            n_sew1 = rv32v_pkg::SEW32;
            n_sew2 = rv32v_pkg::SEW32;
            exec_uop();
            check_value("mem_valu_res", mem_valu_res, shadow[r]);
        end
    endtask

    task automatic alu_ops_test();
        for (int op = 0; op <= 16; op++) begin
            for (int s = 0; s < 3; s++) begin
                for (int n = 0; n < N_PER_WIDTH; n++) begin
                    random_uop();
                    n_op   = 5'(op);
                    n_sew1 = 2'(s);
                    n_sew2 = 2'(s);
                    n_sx   = n[0];
                    exec_uop();
                end
            end
        end
    endtask

    task automatic operand_select_test();
        int mode;
        for (int i = 0; i < N_OPSEL; i++) begin
            random_uop();
            mode      = i % 4;
            n_op      = (rand_bits(1) != 0) ? rv32v_pkg::VALU_ADD : rv32v_pkg::VALU_XOR;
            n_use_imm = mode < 2;
            n_use_rs1 = mode == 2;
            n_use_rs2 = mode == 3;
            if (mode < 2) begin
                n_sx = mode == 0;
            end
            // a compare takes a signed immediate even without vsignext
            if (i % 8 == 5) begin
                n_op = rv32v_pkg::VALU_SLT;
            end
            // rs1 is narrowed unless the micro-op is a memory access
            if (mode == 2) begin
                n_sew2 = rv32v_pkg::SEW32;
                n_memr = i % 8 == 6;
                n_memw = 1'b0;
                if (i % 8 == 2) begin
                    n_sew1 = 2'((i / 8) % 3);
                end
            end
            exec_uop();
        end
    endtask

    task automatic masking_test();
        logic [127:0] v0_bits;
        for (int j = 0; j < 4; j++) begin
            v0_bits[32*j +: 32] = rand_bits(32);
        end
        write_reg(5'd0, v0_bits, 16'hffff);
        for (int i = 0; i < N_MASK; i++) begin
            random_uop();
            n_mask_en = rand_bits(1) != 0;
            n_active  = 4'(rand_bits(4));
            if (i % 2 == 0) begin
                n_op = rv32v_pkg::VALU_MERGE;
            end
            exec_uop();
        end
    endtask

    task automatic back_to_back_test();
        for (int i = 0; i < N_STREAM; i++) begin
            random_uop();
            n_use_imm = rand_bits(1) != 0;
            n_use_rs2 = rand_bits(1) != 0;
            n_mask_en = rand_bits(1) != 0;
            n_active  = 4'(rand_bits(4));
            drive_uop();
            // the previous micro-op was captured at this edge
            if (i > 0) begin
                @(negedge CLK);
                check_oldest();
            end
        end
        @(posedge CLK);
        ex_valid <= 1'b0;
        @(negedge CLK);
        check_oldest();
        @(negedge CLK);
        check_value("mem_{valid,vregwen,memdren,memdwen,lane_mask}",
                    128'({mem_valid, mem_vregwen, mem_memdren, mem_memdwen, mem_lane_mask}),
                    '0);
    endtask

    initial begin
        lfsr          = 32'hbe97_6d0a;
        errors        = 0;
        reset         <= 1'b1;
        ex_valid      <= 1'b0;
        rdat1         <= '0;
        rdat2         <= '0;
        vs1_sel       <= '0;
        vs2_sel       <= '0;
        vd_sel        <= '0;
        veew_src1     <= rv32v_pkg::SEW32;
        veew_src2     <= rv32v_pkg::SEW32;
        veew_dest     <= rv32v_pkg::SEW32;
        vsignext      <= 1'b0;
        vimm          <= '0;
        vxin1_use_imm <= 1'b0;
        vxin1_use_rs1 <= 1'b0;
        vxin2_use_rs2 <= 1'b0;
        valuop        <= rv32v_pkg::VALU_ADD;
        vmask_en      <= 1'b0;
        vuop_num      <= '0;
        vlaneactive   <= '0;
        vmemdren      <= 1'b0;
        vmemdwen      <= 1'b0;
        vregwen       <= 1'b0;
        wb_vd         <= '0;
        wb_vwdata     <= '0;
        wb_byte_wen   <= '0;
        for (int i = 0; i < 32; i++) begin
            shadow[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge CLK);
        reset <= 1'b0;
        reset_state_test();
        write_readback_test();
        alu_ops_test();
        operand_select_test();
        masking_test();
        back_to_back_test();
        @(negedge CLK);
        if (errors == 0) begin
            $display("Test OK");
            $finish;
        end else begin
            $display("Test FAILED");
            $fatal(1, "mismatches were found");
        end
    end

endmodule

// File: vlog.f
source/rv32v_pkg.sv
source/rv32v_vector_bank.sv
source/rv32v_read_xbar.sv
source/rv32v_vfu.sv
source/rv32v_mask_unit.sv
source/rv32v_ex_datapath.sv
testbench/rv32v_ex_datapath_tb.sv

// File: Makefile
# Verilator lint and simulation of the vector execute stage

VERILATOR  ?= verilator
FILELIST   ?= vlog.f
TB_TOP     ?= rv32v_ex_datapath_tb
RTL_TOP    ?= rv32v_ex_datapath
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_MSG   ?= Test OK
LINT_FLAGS ?= -Wall
SIM_FLAGS  ?= --binary --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

$(BUILD_DIR)/V$(TB_TOP): $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TB_TOP)
	./$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || (echo "simulation failed, see $(LOG)" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
